// File: ni_dma_engine.f
+incdir+.
ni_dma_pkg.sv
ni_dma_flit_fifo.sv
ni_dma_send_ctrl.sv
ni_dma_recv_ctrl.sv
ni_dma_engine.sv
tb_ni_dma_engine.sv

// File: ni_dma_engine.sv
// top of the noc dma engine: send and receive controllers, each with its own flit fifo
`timescale 1ns/1ps

module ni_dma_engine #(
    parameter int LEN_W      = 10,
    parameter int FIFO_DEPTH = 8
) (
    input  logic                             clk,
    input  logic                             reset,
    input  logic                             clear_errors_i,
    // send control
    input  logic                             tx_start_i,
    input  logic [ni_dma_pkg::ADDR_W-1:0]    tx_base_i,
    input  logic [LEN_W-1:0]                 tx_size_i,
    input  logic [ni_dma_pkg::DEST_W-1:0]    tx_dest_i,
    output logic                             tx_busy_o,
    output logic                             tx_done_o,
    output logic                             size_err_o,
    output logic                             illegal_req_err_o,
    // wishbone read master
    output logic                             rd_cyc_o,
    output logic                             rd_stb_o,
    output logic [ni_dma_pkg::ADDR_W-1:0]    rd_adr_o,
    input  logic [ni_dma_pkg::DATA_W-1:0]    rd_dat_i,
    input  logic                             rd_ack_i,
    // send link
    output ni_dma_pkg::flit_t                tx_flit_o,
    output logic                             tx_tail_o,
    output logic                             tx_valid_o,
    input  logic                             tx_ready_i,
    // receive control
    input  logic                             rx_start_i,
    input  logic [ni_dma_pkg::ADDR_W-1:0]    rx_base_i,
    input  logic [LEN_W-1:0]                 rx_max_i,
    output logic                             rx_busy_o,
    output logic                             rx_done_o,
    output logic [ni_dma_pkg::DEST_W-1:0]    rx_dest_o,
    output logic [ni_dma_pkg::HDR_LEN_W-1:0] rx_len_o,
    output logic [LEN_W-1:0]                 rx_count_o,
    output logic                             overflow_err_o,
    // wishbone write master
    output logic                             wr_cyc_o,
    output logic                             wr_stb_o,
    output logic [ni_dma_pkg::ADDR_W-1:0]    wr_adr_o,
    output logic [ni_dma_pkg::DATA_W-1:0]    wr_dat_o,
    input  logic                             wr_ack_i,
    // receive link
    input  ni_dma_pkg::flit_t                rx_flit_i,
    input  logic                             rx_tail_i,
    input  logic                             rx_valid_i,
    output logic                             rx_ready_o
);
    import ni_dma_pkg::*;

    flit_t tx_push_data;
    logic  tx_push, tx_push_tail, tx_nearly_full, tx_empty;
    flit_t rx_head_data;
    logic  rx_pop, rx_head_tail, rx_empty, rx_full;

    assign tx_valid_o = !tx_empty;   // head of send fifo is the link flit
    assign rx_ready_o = !rx_full;

    ni_dma_send_ctrl #(.LEN_W(LEN_W)) u_send_ctrl (
        .clk(clk), .reset(reset),
        .tx_start_i(tx_start_i), .tx_base_i(tx_base_i),
        .tx_size_i(tx_size_i), .tx_dest_i(tx_dest_i),
        .clear_errors_i(clear_errors_i),
        .tx_busy_o(tx_busy_o), .tx_done_o(tx_done_o),
        .size_err_o(size_err_o), .illegal_req_err_o(illegal_req_err_o),
        .rd_cyc_o(rd_cyc_o), .rd_stb_o(rd_stb_o), .rd_adr_o(rd_adr_o),
        .rd_dat_i(rd_dat_i), .rd_ack_i(rd_ack_i),
        .fifo_push_o(tx_push), .fifo_data_o(tx_push_data),
        .fifo_tail_o(tx_push_tail), .fifo_nearly_full_i(tx_nearly_full)
    );

    ni_dma_flit_fifo #(.FIFO_DEPTH(FIFO_DEPTH)) u_tx_fifo (
        .clk(clk), .reset(reset),
        .push_i(tx_push), .push_data_i(tx_push_data), .push_tail_i(tx_push_tail),
        .pop_i(tx_valid_o && tx_ready_i),  // flit leaves on handshake
        .head_data_o(tx_flit_o), .head_tail_o(tx_tail_o),
        .empty_o(tx_empty), .full_o(), .nearly_full_o(tx_nearly_full)
    );

    ni_dma_flit_fifo #(.FIFO_DEPTH(FIFO_DEPTH)) u_rx_fifo (
        .clk(clk), .reset(reset),
        .push_i(rx_valid_i && rx_ready_o), .push_data_i(rx_flit_i), .push_tail_i(rx_tail_i),
        .pop_i(rx_pop),
        .head_data_o(rx_head_data), .head_tail_o(rx_head_tail),
        .empty_o(rx_empty), .full_o(rx_full), .nearly_full_o()
    );

    ni_dma_recv_ctrl #(.LEN_W(LEN_W)) u_recv_ctrl (
        .clk(clk), .reset(reset),
        .rx_start_i(rx_start_i), .rx_base_i(rx_base_i), .rx_max_i(rx_max_i),
        .clear_errors_i(clear_errors_i),
        .rx_busy_o(rx_busy_o), .rx_done_o(rx_done_o),
        .rx_dest_o(rx_dest_o), .rx_len_o(rx_len_o), .rx_count_o(rx_count_o),
        .overflow_err_o(overflow_err_o),
        .wr_cyc_o(wr_cyc_o), .wr_stb_o(wr_stb_o), .wr_adr_o(wr_adr_o),
        .wr_dat_o(wr_dat_o), .wr_ack_i(wr_ack_i),
        .fifo_pop_o(rx_pop), .fifo_data_i(rx_head_data),
        .fifo_tail_i(rx_head_tail), .fifo_empty_i(rx_empty)
    );

endmodule

// File: ni_dma_flit_fifo.sv
// first-word-fall-through flit fifo with tail bit, instantiated once per direction in the dma top
`timescale 1ns/1ps

module ni_dma_flit_fifo #(
    parameter int FIFO_DEPTH = 8   // power of two, at least 4
) (
    input  logic              clk,
    input  logic              reset,
    input  logic              push_i,
    input  ni_dma_pkg::flit_t push_data_i,
    input  logic              push_tail_i,
    input  logic              pop_i,
    output ni_dma_pkg::flit_t head_data_o,
    output logic              head_tail_o,
    output logic              empty_o,
    output logic              full_o,
    output logic              nearly_full_o
);
    import ni_dma_pkg::*;

    localparam int PTR_W = $clog2(FIFO_DEPTH);

    flit_t            mem      [FIFO_DEPTH];
    logic             tail_mem [FIFO_DEPTH]; // tail bit kept beside each word
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [PTR_W:0]   count;                 // one extra bit so full is representable

    assign head_data_o   = mem[rd_ptr];      // head visible without a read strobe
    assign head_tail_o   = tail_mem[rd_ptr];
    assign empty_o       = (count == '0);
    assign full_o        = (count == (PTR_W+1)'(FIFO_DEPTH));
    assign nearly_full_o = (count >= (PTR_W+1)'(FIFO_DEPTH - 1)); // one slot or less left

    // storage, no reset needed
    always_ff @(posedge clk) begin
        if (push_i) begin
            mem[wr_ptr]      <= push_data_i;
            tail_mem[wr_ptr] <= push_tail_i;
        end
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push_i) wr_ptr <= wr_ptr + 1'b1; // wraps, depth is a power of two
            if (pop_i)  rd_ptr <= rd_ptr + 1'b1;
            count <= count + (PTR_W+1)'(push_i) - (PTR_W+1)'(pop_i);
        end
    end

    // callers must honour the flags
    a_no_overrun: assert property (@(posedge clk) disable iff (reset) !(push_i && full_o))
        else $error("flit fifo pushed while full");
    a_no_underrun: assert property (@(posedge clk) disable iff (reset) !(pop_i && empty_o))
        else $error("flit fifo popped while empty");

endmodule

// File: ni_dma_pkg.sv
// shared widths and the flit word layout for the noc dma engine, imported by every design file
package ni_dma_pkg;

    localparam int DATA_W     = 32; // flit word and wishbone data width
    localparam int ADDR_W     = 32; // wishbone word address
    localparam int DEST_W     = 8;  // destination id in header
    localparam int HDR_LEN_W  = 16; // payload length in header
    localparam int HDR_RSVD_W = 8;  // pads header to a full word, sent as zero

    // one flit word, read as header fields on the first flit
    // and as a raw payload word on every later flit
    typedef union packed {
        struct packed {
            logic [DEST_W-1:0]     dest_id;
            logic [HDR_LEN_W-1:0]  pkt_len;  // payload words following the header
            logic [HDR_RSVD_W-1:0] reserved;
        } hdr;
        logic [DATA_W-1:0] data;
    } flit_t;

endpackage

// File: ni_dma_recv_ctrl.sv
// receive side of the dma: takes the header from the receive fifo and writes payload over wishbone
`timescale 1ns/1ps

module ni_dma_recv_ctrl #(
    parameter int LEN_W = 10
) (
    input  logic                             clk,
    input  logic                             reset,
    input  logic                             rx_start_i,
    input  logic [ni_dma_pkg::ADDR_W-1:0]    rx_base_i,
    input  logic [LEN_W-1:0]                 rx_max_i,
    input  logic                             clear_errors_i,
    output logic                             rx_busy_o,
    output logic                             rx_done_o,
    output logic [ni_dma_pkg::DEST_W-1:0]    rx_dest_o,
    output logic [ni_dma_pkg::HDR_LEN_W-1:0] rx_len_o,
    output logic [LEN_W-1:0]                 rx_count_o,
    output logic                             overflow_err_o,
    output logic                             wr_cyc_o,
    output logic                             wr_stb_o,
    output logic [ni_dma_pkg::ADDR_W-1:0]    wr_adr_o,
    output logic [ni_dma_pkg::DATA_W-1:0]    wr_dat_o,
    input  logic                             wr_ack_i,
    output logic                             fifo_pop_o,
    input  ni_dma_pkg::flit_t                fifo_data_i,
    input  logic                             fifo_tail_i,
    input  logic                             fifo_empty_i
);
    import ni_dma_pkg::*;

    localparam logic [1:0] S_IDLE = 2'd0;
    localparam logic [1:0] S_HDR  = 2'd1;
    localparam logic [1:0] S_BODY = 2'd2;

    logic [1:0]        state;
    logic [LEN_W-1:0]  max_q;     // buffer limit latched at start
    logic [ADDR_W-1:0] base_q;
    logic              ovf;       // buffer full, later words are dropped
    logic              wr_done;

    assign ovf        = (rx_count_o == max_q);
    assign wr_done    = wr_cyc_o && wr_ack_i;
    assign rx_busy_o  = (state != S_IDLE);
    assign wr_stb_o   = wr_cyc_o;
    assign wr_adr_o   = base_q + ADDR_W'(rx_count_o);
    assign wr_dat_o   = fifo_data_i.data;  // head stays put until the pop on ack
    // header pops at once, payload pops on ack or straight away when dropped
    assign fifo_pop_o = !fifo_empty_i &&
                        ((state == S_HDR) || (state == S_BODY && (ovf || wr_done)));

    always_ff @(posedge clk) begin
        if (state == S_IDLE && rx_start_i) begin
            base_q <= rx_base_i;
            max_q  <= rx_max_i;
        end
        if (state == S_HDR && fifo_pop_o) begin
            rx_dest_o <= fifo_data_i.hdr.dest_id; // first flit decoded as header
            rx_len_o  <= fifo_data_i.hdr.pkt_len;
        end
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            state          <= S_IDLE;
            rx_count_o     <= '0;
            wr_cyc_o       <= 1'b0;
            rx_done_o      <= 1'b0;
            overflow_err_o <= 1'b0;
        end else begin
            rx_done_o <= 1'b0;
            if (clear_errors_i) overflow_err_o <= 1'b0;
            case (state)
                S_IDLE: begin
                    if (rx_start_i) begin
                        state      <= S_HDR;
                        rx_count_o <= '0;
                    end
                end
                S_HDR: begin
                    if (fifo_pop_o) state <= S_BODY;
                end
                S_BODY: begin
                    if (wr_done) begin
                        wr_cyc_o   <= 1'b0;   // one idle cycle between writes
                        rx_count_o <= rx_count_o + 1'b1;
                    end else if (!wr_cyc_o && !fifo_empty_i && !ovf) begin
                        wr_cyc_o <= 1'b1;
                    end
                    if (fifo_pop_o && ovf) overflow_err_o <= 1'b1;
                    if (fifo_pop_o && fifo_tail_i) begin
                        state     <= S_IDLE;  // tail consumed, packet done
                        rx_done_o <= 1'b1;
                    end
                end
                default: state <= S_IDLE;
            endcase
        end
    end

    initial assert (LEN_W <= HDR_LEN_W) else $error("recv LEN_W wider than header length field");

    // write data comes from the fifo head, so this also checks the fifo holds it
    a_wr_hold: assert property (@(posedge clk) disable iff (reset)
        wr_cyc_o && !wr_ack_i |=> wr_cyc_o && $stable(wr_adr_o) && $stable(wr_dat_o))
        else $error("write cycle dropped or changed before ack");

endmodule

// File: ni_dma_send_ctrl.sv
// send side of the dma: builds the header flit, then reads payload over wishbone into the send fifo
`timescale 1ns/1ps

module ni_dma_send_ctrl #(
    parameter int LEN_W = 10
) (
    input  logic                          clk,
    input  logic                          reset,
    input  logic                          tx_start_i,
    input  logic [ni_dma_pkg::ADDR_W-1:0] tx_base_i,
    input  logic [LEN_W-1:0]              tx_size_i,
    input  logic [ni_dma_pkg::DEST_W-1:0] tx_dest_i,
    input  logic                          clear_errors_i,
    output logic                          tx_busy_o,
    output logic                          tx_done_o,
    output logic                          size_err_o,
    output logic                          illegal_req_err_o,
    output logic                          rd_cyc_o,
    output logic                          rd_stb_o,
    output logic [ni_dma_pkg::ADDR_W-1:0] rd_adr_o,
    input  logic [ni_dma_pkg::DATA_W-1:0] rd_dat_i,
    input  logic                          rd_ack_i,
    output logic                          fifo_push_o,
    output ni_dma_pkg::flit_t             fifo_data_o,
    output logic                          fifo_tail_o,
    input  logic                          fifo_nearly_full_i
);
    import ni_dma_pkg::*;

    localparam logic [1:0] S_IDLE = 2'd0;
    localparam logic [1:0] S_HDR  = 2'd1;
    localparam logic [1:0] S_BODY = 2'd2;

    logic [1:0]        state;
    logic [LEN_W-1:0]  word_cnt;   // index of the word being read
    logic [LEN_W-1:0]  size_q;     // request latched at start
    logic [ADDR_W-1:0] base_q;
    logic [DEST_W-1:0] dest_q;
    logic              last_word;
    logic              hdr_push;
    logic              data_push;

    assign last_word   = (word_cnt == size_q - 1'b1);
    assign hdr_push    = (state == S_HDR) && !fifo_nearly_full_i;
    assign data_push   = rd_cyc_o && rd_ack_i;     // read data goes straight into the fifo
    assign fifo_push_o = hdr_push || data_push;
    assign fifo_tail_o = data_push && last_word;
    assign tx_busy_o   = (state != S_IDLE);
    assign rd_stb_o    = rd_cyc_o;                 // classic cycle, stb follows cyc
    assign rd_adr_o    = base_q + ADDR_W'(word_cnt);

    // header view in the header state, payload view otherwise
    always_comb begin
        fifo_data_o = '0;                          // reserved bits stay zero
        if (state == S_HDR) begin
            fifo_data_o.hdr.dest_id = dest_q;
            fifo_data_o.hdr.pkt_len = HDR_LEN_W'(size_q);
        end else begin
            fifo_data_o.data = rd_dat_i;
        end
    end

    always_ff @(posedge clk) begin
        if (state == S_IDLE && tx_start_i) begin
            size_q <= tx_size_i;
            base_q <= tx_base_i;
            dest_q <= tx_dest_i;
        end
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            state             <= S_IDLE;
            word_cnt          <= '0;
            rd_cyc_o          <= 1'b0;
            tx_done_o         <= 1'b0;
            size_err_o        <= 1'b0;
            illegal_req_err_o <= 1'b0;
        end else begin
            tx_done_o <= 1'b0;
            if (clear_errors_i) begin
                size_err_o        <= 1'b0;
                illegal_req_err_o <= 1'b0;
            end
            case (state)
                S_IDLE: begin
                    if (tx_start_i) begin
                        if (tx_size_i == '0) begin
                            size_err_o <= 1'b1; // nothing to send, stay idle
                        end else begin
                            state    <= S_HDR;
                            word_cnt <= '0;
                        end
                    end
                end
                S_HDR: begin
                    if (hdr_push) state <= S_BODY;
                end
                S_BODY: begin
                    if (data_push) begin
                        rd_cyc_o <= 1'b0;       // bus idles at least one cycle
                        word_cnt <= word_cnt + 1'b1;
                        if (last_word) begin
                            state     <= S_IDLE;
                            tx_done_o <= 1'b1;
                        end
                    end else if (!rd_cyc_o && !fifo_nearly_full_i) begin
                        rd_cyc_o <= 1'b1;       // room for the data when ack comes
                    end
                end
                default: state <= S_IDLE;
            endcase
            if (tx_start_i && state != S_IDLE) illegal_req_err_o <= 1'b1; // start ignored
        end
    end

    initial assert (LEN_W <= HDR_LEN_W) else $error("send LEN_W wider than header length field");

    // the slave may only ack a read cycle that is open
    a_rd_ack_in_cycle: assert property (@(posedge clk) disable iff (reset)
        rd_ack_i |-> rd_cyc_o)
        else $error("read ack outside an open read cycle");

endmodule

// File: tb_ni_dma_checks.svh
// helpers of the dma testbench, included inside the testbench top after its signal declarations
`ifndef TB_NI_DMA_CHECKS_SVH
`define TB_NI_DMA_CHECKS_SVH

    flit_t exp_flits [$];  // send link flits still to come, in order
    logic  exp_tails [$];

    // numerical recipes constants
    function automatic logic [31:0] lcg_step(logic [31:0] state);
        return state * 32'd1664525 + 32'd1013904223;
    endfunction

    // stimulus stream, only used by the sequence process
    function automatic logic [31:0] next_rand();
        stim_rng = lcg_step(stim_rng);
        return stim_rng;
    endfunction

    task automatic report_failure(string what);
        fail_cnt++;
        $display("%s, at %0t ns", what, $time);
    endtask

    task automatic check_word(string name, logic [DATA_W-1:0] exp, logic [DATA_W-1:0] act);
        check_cnt++;
        if (act !== exp) begin
            mismatch_cnt++;
            $display("Mismatch at %0t ns: %s expected %h actual %h", $time, name, exp, act);
        end
    endtask

    task automatic check_flag(string name, logic exp, logic act);
        check_cnt++;
        if (act !== exp) begin
            mismatch_cnt++;
            $display("Mismatch at %0t ns: %s expected %b actual %b", $time, name, exp, act);
        end
    endtask

    task automatic check_flit(string name, flit_t exp, logic exp_tail, flit_t act, logic act_tail);
        check_cnt++;
        if ({act_tail, act} !== {exp_tail, exp}) begin
            mismatch_cnt++;
            $display("Mismatch at %0t ns: %s expected tail %b flit %h actual tail %b flit %h",
                     $time, name, exp_tail, exp, act_tail, act);
        end
    endtask

    // header first, then payload from memory, tail only on the last word
    task automatic expect_packet(logic [DEST_W-1:0] dest, int size, logic [ADDR_W-1:0] base);
        flit_t f;
        f             = '0;
        f.hdr.dest_id = dest;
        f.hdr.pkt_len = HDR_LEN_W'(size);
        exp_flits.push_back(f);
        exp_tails.push_back(1'b0);
        for (int i = 0; i < size; i++) begin
            f.data = mem_read(base + i);
            exp_flits.push_back(f);
            exp_tails.push_back(i == size - 1);
        end
    endtask

    task automatic check_link_flit(flit_t act, logic act_tail);
        flit_t exp;
        logic  exp_tail;
        if (exp_flits.size() == 0) begin
            report_failure("flit left the send link while none was expected");
        end else begin
            exp      = exp_flits.pop_front();
            exp_tail = exp_tails.pop_front();
            check_flit("tx_flit_o", exp, exp_tail, act, act_tail);
        end
    endtask

`endif

// File: tb_ni_dma_engine.sv
// random packet testbench that loops the dma send link back into the receive link, run as top
`timescale 1ns/1ps

module tb_ni_dma_engine;
    import ni_dma_pkg::*;

    localparam int LEN_W       = 10;
    localparam int FIFO_DEPTH  = 8;
    localparam int NUM_PKTS    = 40;
    localparam int MAX_WORDS   = 64;
    localparam int RX_LIMIT    = 2**LEN_W - 1;      // larger than any packet here
    localparam int WATCHDOG_NS = NUM_PKTS * MAX_WORDS * 10 * 100;

    logic                 clk, reset, clear_errors;
    logic                 tx_start, tx_busy, tx_done, size_err, illegal_req_err;
    logic                 rx_start, rx_busy, rx_done, overflow_err;
    logic [ADDR_W-1:0]    tx_base, rx_base, rd_adr, wr_adr;
    logic [LEN_W-1:0]     tx_size, rx_max, rx_count;
    logic [DEST_W-1:0]    tx_dest, rx_dest;
    logic [HDR_LEN_W-1:0] rx_len;
    logic [DATA_W-1:0]    rd_dat, wr_dat;
    logic                 rd_cyc, rd_stb, rd_ack, wr_cyc, wr_stb, wr_ack;
    flit_t                tx_flit;
    logic                 tx_tail, tx_valid, tx_ready, rx_valid, rx_ready;
    logic                 link_open;                 // stall gate on the loopback
    logic [DATA_W-1:0]    mem [logic [ADDR_W-1:0]];  // sparse, serves both slaves
    logic [31:0]          stim_rng, rd_rng, wr_rng, link_rng;
    int                   rd_wait, wr_wait;          // idle cycles before next ack
    int                   tx_done_cnt, rx_done_cnt;
    int                   check_cnt, mismatch_cnt, fail_cnt;

    assign rx_valid = tx_valid && link_open;
    assign tx_ready = rx_ready && link_open;

    // unwritten words read as a pattern of the whole address
    function automatic logic [DATA_W-1:0] mem_read(logic [ADDR_W-1:0] addr);
        if (mem.exists(addr)) return mem[addr];
        return addr ^ {addr[15:0], addr[31:16]} ^ 32'h3c5a_a5c3;
    endfunction

    `include "tb_ni_dma_checks.svh"

    ni_dma_engine #(.LEN_W(LEN_W), .FIFO_DEPTH(FIFO_DEPTH)) u_ni_dma_engine (
        .clk(clk), .reset(reset), .clear_errors_i(clear_errors),
        .tx_start_i(tx_start), .tx_base_i(tx_base), .tx_size_i(tx_size), .tx_dest_i(tx_dest),
        .tx_busy_o(tx_busy), .tx_done_o(tx_done),
        .size_err_o(size_err), .illegal_req_err_o(illegal_req_err),
        .rd_cyc_o(rd_cyc), .rd_stb_o(rd_stb), .rd_adr_o(rd_adr),
        .rd_dat_i(rd_dat), .rd_ack_i(rd_ack),
        .tx_flit_o(tx_flit), .tx_tail_o(tx_tail), .tx_valid_o(tx_valid), .tx_ready_i(tx_ready),
        .rx_start_i(rx_start), .rx_base_i(rx_base), .rx_max_i(rx_max),
        .rx_busy_o(rx_busy), .rx_done_o(rx_done), .rx_dest_o(rx_dest), .rx_len_o(rx_len),
        .rx_count_o(rx_count), .overflow_err_o(overflow_err),
        .wr_cyc_o(wr_cyc), .wr_stb_o(wr_stb), .wr_adr_o(wr_adr),
        .wr_dat_o(wr_dat), .wr_ack_i(wr_ack),
        .rx_flit_i(tx_flit), .rx_tail_i(tx_tail), .rx_valid_i(rx_valid), .rx_ready_o(rx_ready)
    );

    initial clk = 1'b0;
    always #50 clk = ~clk;

    // read slave, ack after 0 to 3 wait cycles
    always @(posedge clk) begin
        rd_ack <= 1'b0;
        if (rd_cyc && rd_stb && !rd_ack) begin
            if (rd_wait == 0) begin
                rd_ack  <= 1'b1;
                rd_dat  <= mem_read(rd_adr);
                rd_rng  = lcg_step(rd_rng);
                rd_wait <= rd_rng[31:30];
            end else begin
                rd_wait <= rd_wait - 1;
            end
        end
    end

    // write slave, same timing
    always @(posedge clk) begin
        wr_ack <= 1'b0;
        if (wr_cyc && wr_stb && !wr_ack) begin
            if (wr_wait == 0) begin
                wr_ack      <= 1'b1;
                mem[wr_adr] = wr_dat;
                wr_rng      = lcg_step(wr_rng);
                wr_wait     <= wr_rng[31:30];
            end else begin
                wr_wait <= wr_wait - 1;
            end
        end
    end

    always @(posedge clk) begin
        link_rng  = lcg_step(link_rng);
        link_open <= (link_rng[31:30] != 2'b00); // closed about a quarter of cycles
    end

    // link flits against the queue, done pulses counted
    always @(posedge clk) begin
        if (!reset && tx_valid && tx_ready) check_link_flit(tx_flit, tx_tail);
        if (tx_done) tx_done_cnt <= tx_done_cnt + 1;
        if (rx_done) rx_done_cnt <= rx_done_cnt + 1;
    end

    initial begin
        #(WATCHDOG_NS);
        $display("watchdog stopped the run after %0d ns, a transfer never finished", WATCHDOG_NS);
        $display("TB FAILED");
        $finish;
    end

    task automatic clear_flags();
        @(posedge clk);
        clear_errors <= 1'b1;
        @(posedge clk);
        clear_errors <= 1'b0;
        @(posedge clk);
        check_flag("size_err_o", 1'b0, size_err);
        check_flag("illegal_req_err_o", 1'b0, illegal_req_err);
        check_flag("overflow_err_o", 1'b0, overflow_err);
    endtask

    task automatic run_size_zero();
        @(posedge clk);
        tx_start <= 1'b1;
        tx_size  <= '0;
        @(posedge clk);
        tx_start <= 1'b0;
        repeat (6) begin
            @(posedge clk);
            check_flag("tx_busy_o", 1'b0, tx_busy);
        end
        check_flag("size_err_o", 1'b1, size_err);
        clear_flags();
    endtask

    // one packet sent and received in loopback, optional second start while busy
    task automatic run_packet(int pkt, int size, int max, bit busy_start);
        logic [31:0]       r;
        logic [ADDR_W-1:0] src;
        logic [ADDR_W-1:0] dst;
        logic [DEST_W-1:0] dest;
        logic [DATA_W-1:0] payload [$];
        int                kept;
        int                tx_before;
        int                rx_before;
        r    = next_rand();
        src  = {8'h00, r[23:0]};
        dst  = 32'h1000_0000 + (pkt << 8) + r[29:24];  // fresh receive region per packet
        r    = next_rand();
        dest = r[31:24];
        for (int i = 0; i < size; i++) begin
            mem[src + i] = next_rand();
            payload.push_back(mem[src + i]);
        end
        expect_packet(dest, size, src);
        kept      = (size < max) ? size : max;
        tx_before = tx_done_cnt;
        rx_before = rx_done_cnt;
        @(posedge clk);
        tx_start <= 1'b1;
        rx_start <= 1'b1;
        tx_base  <= src;
        tx_size  <= LEN_W'(size);
        tx_dest  <= dest;
        rx_base  <= dst;
        rx_max   <= LEN_W'(max);
        @(posedge clk);
        tx_start <= 1'b0;
        rx_start <= 1'b0;
        if (busy_start) begin
            @(posedge clk);
            check_flag("tx_busy_o", 1'b1, tx_busy);
            check_flag("rx_busy_o", 1'b1, rx_busy);
            tx_start <= 1'b1;
            tx_dest  <= ~dest;              // must not show up in the header
            @(posedge clk);
            tx_start <= 1'b0;
        end
        while (tx_done_cnt == tx_before || rx_done_cnt == rx_before) @(posedge clk);
        repeat (3) @(posedge clk);
        check_word("tx_done_o pulses", 1, tx_done_cnt - tx_before);
        check_word("rx_done_o pulses", 1, rx_done_cnt - rx_before);
        check_flag("tx_busy_o", 1'b0, tx_busy);
        check_flag("rx_busy_o", 1'b0, rx_busy);
        if (exp_flits.size() != 0) report_failure("expected flits never left the send link");
        check_word("rx_dest_o", dest, rx_dest);
        check_word("rx_len_o", size, rx_len);
        check_word("rx_count_o", kept, rx_count);
        check_flag("overflow_err_o", size > max, overflow_err);
        if (busy_start) check_flag("illegal_req_err_o", 1'b1, illegal_req_err);
        for (int i = 0; i < size; i++) begin
            if (i < kept) check_word("received word", payload[i], mem_read(dst + i));
            else if (mem.exists(dst + i)) report_failure("word written past the receive limit");
        end
        if (size > max || busy_start) clear_flags();
    endtask

    initial begin
        logic [31:0] r;
        stim_rng     = 32'he6f1a101;
        rd_rng       = 32'he6f1a101 ^ 32'h0000_1111; // one generator state per process
        wr_rng       = 32'he6f1a101 ^ 32'h0000_2222;
        link_rng     = 32'he6f1a101 ^ 32'h0000_3333;
        rd_wait      = 0;
        wr_wait      = 0;
        tx_done_cnt  = 0;
        rx_done_cnt  = 0;
        check_cnt    = 0;
        mismatch_cnt = 0;
        fail_cnt     = 0;
        reset        <= 1'b1;
        clear_errors <= 1'b0;
        tx_start     <= 1'b0;
        tx_base      <= '0;
        tx_size      <= '0;
        tx_dest      <= '0;
        rx_start     <= 1'b0;
        rx_base      <= '0;
        rx_max       <= '0;
        rd_dat       <= '0;
        rd_ack       <= 1'b0;
        wr_ack       <= 1'b0;
        link_open    <= 1'b0;
        repeat (16) @(posedge clk);
        check_flag("tx_valid_o", 1'b0, tx_valid);
        check_flag("rx_ready_o", 1'b1, rx_ready);
        check_flag("rd_cyc_o", 1'b0, rd_cyc);
        check_flag("rd_stb_o", 1'b0, rd_stb);
        check_flag("wr_cyc_o", 1'b0, wr_cyc);
        check_flag("wr_stb_o", 1'b0, wr_stb);
        check_flag("tx_busy_o", 1'b0, tx_busy);
        check_flag("rx_busy_o", 1'b0, rx_busy);
        check_flag("tx_done_o", 1'b0, tx_done);
        check_flag("rx_done_o", 1'b0, rx_done);
        check_flag("size_err_o", 1'b0, size_err);
        check_flag("illegal_req_err_o", 1'b0, illegal_req_err);
        check_flag("overflow_err_o", 1'b0, overflow_err);
        reset <= 1'b0;
        for (int p = 0; p < NUM_PKTS; p++) begin
            r = next_rand();
            if (p == 5) run_size_zero();
            else if (p == 10) run_packet(p, 2 + r[31:27], RX_LIMIT, 1'b1); // start while busy
            else if (p == 15) run_packet(p, 20, 7, 1'b0);                  // receive overflow
            else run_packet(p, 1 + r[31:26], RX_LIMIT, 1'b0);
        end
        repeat (4) @(posedge clk);
        $display("checks %0d, mismatches %0d, other errors %0d", check_cnt, mismatch_cnt, fail_cnt);
        if (mismatch_cnt == 0 && fail_cnt == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

endmodule
